//--- source/dma_pkg.sv
package dma_pkg;

  // --------------------------------------------------------------------------
  // Bus and field widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int LEN_W   = 32;
  localparam int BURST_W = 4;
  localparam int LEVEL_W = 5;
  localparam int RESP_W  = 2;

  // --------------------------------------------------------------------------
  // TX FIFO and word geometry
  // --------------------------------------------------------------------------
  // Capacity of the TX FIFO in words
  localparam int TX_FIFO_DEPTH = 16;

  // One AXI4-Lite beat moves one full word
  localparam int WORD_BYTES = 4;

  // --------------------------------------------------------------------------
  // State encodings
  // --------------------------------------------------------------------------
  // Sequencer: gate each burst on FIFO room, run it, loop or finish
  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_SPACE,
    S_RUN,
    S_DONE
  } dma_state_e;

  // Read engine: one AR phase and one R phase per word
  typedef enum logic [1:0] {
    B_IDLE,
    B_ADDR,
    B_DATA
  } beat_state_e;

endpackage

//--- source/dma_sequencer.sv
`timescale 1ns/1ps

module dma_sequencer (
  input  logic clk,
  input  logic resetn,
  input  logic start_i,
  input  logic space_ok_i,
  input  logic rem_zero_i,
  input  logic beats_done_i,
  input  logic resp_err_i,
  output logic load_o,
  output logic burst_start_o,
  output logic burst_end_o,
  output logic busy_o,
  output logic done_o,
  output logic err_o
);

  dma_pkg::dma_state_e state;
  logic                err_q;
  logic                done_q;

  // --------------------------------------------------------------------------
  // Strobes to the counter and read engine
  // --------------------------------------------------------------------------
  // New configuration only accepted while idle
  assign load_o = start_i && (state == dma_pkg::S_IDLE);

  // Launch a burst once the FIFO can take all of its words
  assign burst_start_o = (state == dma_pkg::S_WAIT_SPACE) && !rem_zero_i && space_ok_i;

  // Counter bookkeeping at the end of every burst
  assign burst_end_o = (state == dma_pkg::S_RUN) && beats_done_i;

  // Status
  assign busy_o = (state != dma_pkg::S_IDLE);
  assign done_o = done_q;
  assign err_o  = err_q;

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= dma_pkg::S_IDLE;
      err_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      // Done pulse follows the DONE cycle
      done_q <= (state == dma_pkg::S_DONE);

      case (state)
        dma_pkg::S_IDLE: begin
          if (start_i) begin
            // Error flag lives until the next transfer begins
            err_q <= 1'b0;
            state <= dma_pkg::S_WAIT_SPACE;
          end
        end

        dma_pkg::S_WAIT_SPACE: begin
          if (rem_zero_i) begin
            state <= dma_pkg::S_DONE;
          end else if (space_ok_i) begin
            state <= dma_pkg::S_RUN;
          end
        end

        dma_pkg::S_RUN: begin
          if (resp_err_i) begin
            err_q <= 1'b1;
          end
          if (beats_done_i) begin
            // Bad response finishes the transfer after this burst
            if (err_q) begin
              state <= dma_pkg::S_DONE;
            end else begin
              state <= dma_pkg::S_WAIT_SPACE;
            end
          end
        end

        dma_pkg::S_DONE: begin
          state <= dma_pkg::S_IDLE;
        end

        default: begin
          state <= dma_pkg::S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- source/dma_burst_counter.sv
`timescale 1ns/1ps

module dma_burst_counter (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        load_i,
  input  logic [dma_pkg::ADDR_W-1:0]  addr_i,
  input  logic [dma_pkg::LEN_W-1:0]   len_i,
  input  logic [dma_pkg::BURST_W-1:0] burst_size_i,
  input  logic                        incr_addr_i,
  input  logic [dma_pkg::LEVEL_W-1:0] tx_level_i,
  input  logic                        burst_end_i,
  output logic [dma_pkg::ADDR_W-1:0]  burst_addr_o,
  output logic [dma_pkg::BURST_W-1:0] burst_beats_o,
  output logic                        space_ok_o,
  output logic                        rem_zero_o
);

  // Transfer configuration and progress
  logic [dma_pkg::LEN_W-1:0]   rem_bytes;
  logic [dma_pkg::ADDR_W-1:0]  base_addr;
  logic [dma_pkg::BURST_W-1:0] burst_size_q;
  logic                        incr_q;

  // Next-burst sizing
  logic [dma_pkg::LEN_W-1:0]   rem_words;
  logic [dma_pkg::BURST_W-1:0] burst_words;
  logic [dma_pkg::BURST_W-1:0] beats;
  logic [dma_pkg::LEN_W-1:0]   beats_len;
  logic [dma_pkg::ADDR_W-1:0]  beats_addr;
  logic [dma_pkg::LEN_W-1:0]   burst_bytes;
  logic [dma_pkg::ADDR_W-1:0]  addr_step;
  logic [dma_pkg::LEVEL_W:0]   fill_level;

  // --------------------------------------------------------------------------
  // Sizing of the next burst
  // --------------------------------------------------------------------------
  // Trailing bytes below one word are dropped
  assign rem_words  = rem_bytes / dma_pkg::WORD_BYTES;
  assign rem_zero_o = (rem_words == '0);

  // Zero burst size behaves as single-word bursts
  assign burst_words = (burst_size_q == '0) ? dma_pkg::BURST_W'(1) : burst_size_q;
  assign beats = (rem_words < burst_words) ? rem_words[dma_pkg::BURST_W-1:0] : burst_words;

  assign beats_len   = {{(dma_pkg::LEN_W - dma_pkg::BURST_W){1'b0}}, beats};
  assign beats_addr  = {{(dma_pkg::ADDR_W - dma_pkg::BURST_W){1'b0}}, beats};
  assign burst_bytes = beats_len * dma_pkg::WORD_BYTES;
  assign addr_step   = beats_addr * dma_pkg::WORD_BYTES;

  // One spare bit so level plus beats cannot wrap
  assign fill_level = {1'b0, tx_level_i} +
                      {{(dma_pkg::LEVEL_W + 1 - dma_pkg::BURST_W){1'b0}}, beats};
  assign space_ok_o = (fill_level <= dma_pkg::TX_FIFO_DEPTH);

  assign burst_addr_o  = base_addr;
  assign burst_beats_o = beats;

  // --------------------------------------------------------------------------
  // Remaining bytes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rem_bytes <= '0;
    end else if (load_i) begin
      rem_bytes <= len_i;
    end else if (burst_end_i) begin
      // Clamp so a short tail never wraps the count
      if (rem_bytes > burst_bytes) begin
        rem_bytes <= rem_bytes - burst_bytes;
      end else begin
        rem_bytes <= '0;
      end
    end
  end

  // Configuration and burst base address
  always_ff @(posedge clk) begin
    if (load_i) begin
      base_addr    <= addr_i;
      burst_size_q <= burst_size_i;
      incr_q       <= incr_addr_i;
    end else if (burst_end_i && incr_q) begin
      base_addr <= base_addr + addr_step;
    end
  end

endmodule

//--- source/axi_read_beats.sv
`timescale 1ns/1ps

module axi_read_beats (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        start_i,
  input  logic [dma_pkg::ADDR_W-1:0]  addr_i,
  input  logic [dma_pkg::BURST_W-1:0] beats_i,
  input  logic                        arready_i,
  input  logic                        rvalid_i,
  input  logic [dma_pkg::DATA_W-1:0]  rdata_i,
  input  logic [dma_pkg::RESP_W-1:0]  rresp_i,
  input  logic                        tx_full_i,
  output logic [dma_pkg::ADDR_W-1:0]  araddr_o,
  output logic                        arvalid_o,
  output logic                        rready_o,
  output logic [dma_pkg::DATA_W-1:0]  fifo_tx_data_o,
  output logic                        fifo_tx_we_o,
  output logic                        beats_done_o,
  output logic                        resp_err_o
);

  dma_pkg::beat_state_e        state;
  logic [dma_pkg::BURST_W-1:0] beats_left;
  logic                        beat_taken;

  // Accept read data only when the FIFO has a free slot
  assign rready_o   = (state == dma_pkg::B_DATA) && !tx_full_i;
  assign beat_taken = rvalid_i && rready_o;

  // --------------------------------------------------------------------------
  // AR/R sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= dma_pkg::B_IDLE;
      beats_left   <= '0;
      arvalid_o    <= 1'b0;
      fifo_tx_we_o <= 1'b0;
      beats_done_o <= 1'b0;
      resp_err_o   <= 1'b0;
    end else begin
      fifo_tx_we_o <= 1'b0;
      resp_err_o   <= 1'b0;

      // Burst is finished once the last word has been pushed
      beats_done_o <= fifo_tx_we_o && (beats_left == '0);

      case (state)
        dma_pkg::B_IDLE: begin
          if (start_i) begin
            beats_left <= beats_i;
            arvalid_o  <= 1'b1;
            state      <= dma_pkg::B_ADDR;
          end
        end

        dma_pkg::B_ADDR: begin
          // Hold the request until the slave takes it
          if (arready_i) begin
            arvalid_o <= 1'b0;
            state     <= dma_pkg::B_DATA;
          end
        end

        dma_pkg::B_DATA: begin
          if (beat_taken) begin
            fifo_tx_we_o <= 1'b1;
            resp_err_o   <= rresp_i[1];
            beats_left   <= beats_left - 1'b1;
            if (beats_left == dma_pkg::BURST_W'(1)) begin
              state <= dma_pkg::B_IDLE;
            end else begin
              arvalid_o <= 1'b1;
              state     <= dma_pkg::B_ADDR;
            end
          end
        end

        default: begin
          state <= dma_pkg::B_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Address and data payload
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if ((state == dma_pkg::B_IDLE) && start_i) begin
      // Word aligned start
      araddr_o <= {addr_i[dma_pkg::ADDR_W-1:2], 2'b00};
    end else if ((state == dma_pkg::B_DATA) && beat_taken) begin
      araddr_o <= araddr_o + dma_pkg::WORD_BYTES;
    end
    if (beat_taken) begin
      fifo_tx_data_o <= rdata_i;
    end
  end

endmodule

//--- source/dma_read_top.sv
`timescale 1ns/1ps

module dma_read_top (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        dma_en_i,
  input  logic [dma_pkg::BURST_W-1:0] burst_size_i,
  input  logic                        incr_addr_i,
  input  logic [dma_pkg::ADDR_W-1:0]  dma_addr_i,
  input  logic [dma_pkg::LEN_W-1:0]   dma_len_i,
  input  logic [dma_pkg::LEVEL_W-1:0] tx_level_i,
  input  logic                        arready_i,
  input  logic [dma_pkg::DATA_W-1:0]  rdata_i,
  input  logic                        rvalid_i,
  input  logic [dma_pkg::RESP_W-1:0]  rresp_i,
  output logic [dma_pkg::DATA_W-1:0]  fifo_tx_data_o,
  output logic                        fifo_tx_we_o,
  output logic [dma_pkg::ADDR_W-1:0]  araddr_o,
  output logic                        arvalid_o,
  output logic                        rready_o,
  output logic                        dma_done_set_o,
  output logic                        axi_err_o,
  output logic                        busy_o
);

  logic                        dma_en_q;
  logic                        start_pulse;
  logic                        tx_full;
  logic                        load;
  logic                        burst_start;
  logic                        burst_end;
  logic                        space_ok;
  logic                        rem_zero;
  logic                        beats_done;
  logic                        resp_err;
  logic [dma_pkg::ADDR_W-1:0]  burst_addr;
  logic [dma_pkg::BURST_W-1:0] burst_beats;

  // --------------------------------------------------------------------------
  // Enable edge and FIFO status
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      dma_en_q <= 1'b0;
    end else begin
      dma_en_q <= dma_en_i;
    end
  end

  assign start_pulse = dma_en_i && !dma_en_q;
  assign tx_full     = (tx_level_i >= dma_pkg::TX_FIFO_DEPTH);

  // --------------------------------------------------------------------------
  // Sub-blocks
  // --------------------------------------------------------------------------
  dma_sequencer u_sequencer (
    .clk           (clk),
    .resetn        (resetn),
    .start_i       (start_pulse),
    .space_ok_i    (space_ok),
    .rem_zero_i    (rem_zero),
    .beats_done_i  (beats_done),
    .resp_err_i    (resp_err),
    .load_o        (load),
    .burst_start_o (burst_start),
    .burst_end_o   (burst_end),
    .busy_o        (busy_o),
    .done_o        (dma_done_set_o),
    .err_o         (axi_err_o)
  );

  dma_burst_counter u_burst_counter (
    .clk           (clk),
    .resetn        (resetn),
    .load_i        (load),
    .addr_i        (dma_addr_i),
    .len_i         (dma_len_i),
    .burst_size_i  (burst_size_i),
    .incr_addr_i   (incr_addr_i),
    .tx_level_i    (tx_level_i),
    .burst_end_i   (burst_end),
    .burst_addr_o  (burst_addr),
    .burst_beats_o (burst_beats),
    .space_ok_o    (space_ok),
    .rem_zero_o    (rem_zero)
  );

  axi_read_beats u_read_beats (
    .clk            (clk),
    .resetn         (resetn),
    .start_i        (burst_start),
    .addr_i         (burst_addr),
    .beats_i        (burst_beats),
    .arready_i      (arready_i),
    .rvalid_i       (rvalid_i),
    .rdata_i        (rdata_i),
    .rresp_i        (rresp_i),
    .tx_full_i      (tx_full),
    .araddr_o       (araddr_o),
    .arvalid_o      (arvalid_o),
    .rready_o       (rready_o),
    .fifo_tx_data_o (fifo_tx_data_o),
    .fifo_tx_we_o   (fifo_tx_we_o),
    .beats_done_o   (beats_done),
    .resp_err_o     (resp_err)
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

endmodule

//--- sim/dma_read_tb.sv
`timescale 1ns/1ps

module dma_read_tb;

  localparam logic [31:0] SEED      = 32'h4341_4177;
  localparam logic [31:0] PATTERN   = 32'hA5C3_0F96;
  localparam int          NUM_TESTS = 5;
  localparam int          NUM_XFERS = 6;
  localparam int          DEPTH     = dma_pkg::TX_FIFO_DEPTH;

  logic        clk;
  logic        resetn;
  logic        dma_en_i;
  logic [3:0]  burst_size_i;
  logic        incr_addr_i;
  logic [31:0] dma_addr_i;
  logic [31:0] dma_len_i;
  logic [4:0]  tx_level_i;
  logic        arready_i;
  logic [31:0] rdata_i;
  logic        rvalid_i;
  logic [1:0]  rresp_i;
  logic [31:0] fifo_tx_data_o;
  logic        fifo_tx_we_o;
  logic [31:0] araddr_o;
  logic        arvalid_o;
  logic        rready_o;
  logic        dma_done_set_o;
  logic        axi_err_o;
  logic        busy_o;

  // Transfer table filled at time zero
  logic [31:0] cfg_addr [NUM_XFERS];
  logic [31:0] cfg_len [NUM_XFERS];
  logic [3:0]  cfg_burst [NUM_XFERS];
  logic        cfg_incr [NUM_XFERS];
  logic        cfg_slow [NUM_XFERS];
  logic        cfg_err_en [NUM_XFERS];
  logic [31:0] cfg_err_addr [NUM_XFERS];

  logic [31:0] exp_addr [$];
  logic [31:0] got_addr [$];
  logic [31:0] got_data [$];

  logic [31:0] lfsr = SEED;
  int          errors = 0;
  int          tests_failed = 0;
  int          done_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          fifo_level = 0;
  logic        slow_drain = 1'b0;
  logic        err_en = 1'b0;
  logic [31:0] err_addr = '0;
  logic        r_busy = 1'b0;
  int          r_wait = 0;
  int          ar_wait = 0;
  logic [31:0] r_addr = '0;

  tb_clock_gen u_clock (.clk_o(clk));

  dma_read_top dut (
    .clk            (clk),
    .resetn         (resetn),
    .dma_en_i       (dma_en_i),
    .burst_size_i   (burst_size_i),
    .incr_addr_i    (incr_addr_i),
    .dma_addr_i     (dma_addr_i),
    .dma_len_i      (dma_len_i),
    .tx_level_i     (tx_level_i),
    .arready_i      (arready_i),
    .rdata_i        (rdata_i),
    .rvalid_i       (rvalid_i),
    .rresp_i        (rresp_i),
    .fifo_tx_data_o (fifo_tx_data_o),
    .fifo_tx_we_o   (fifo_tx_we_o),
    .araddr_o       (araddr_o),
    .arvalid_o      (arvalid_o),
    .rready_o       (rready_o),
    .dma_done_set_o (dma_done_set_o),
    .axi_err_o      (axi_err_o),
    .busy_o         (busy_o)
  );

  // ------------------------------------------------------------------------
  // Random numbers and reporting
  // ------------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Failure: %s", msg);
  endtask

  // ------------------------------------------------------------------------
  // Transfer model
  // ------------------------------------------------------------------------
  // Fills exp_addr with the reads the DMA should make and returns the word count
  function automatic int expected_reads(input int t);
    int          words;
    int          bsz;
    int          beats;
    int          done_words;
    logic [31:0] base;
    logic        hit;
    exp_addr.delete();
    words = cfg_len[t] / 4;
    bsz = (cfg_burst[t] == 4'd0) ? 1 : int'(cfg_burst[t]);
    base = {cfg_addr[t][31:2], 2'b00};
    done_words = 0;
    hit = 1'b0;
    while (done_words < words && !hit) begin
      beats = (words - done_words < bsz) ? words - done_words : bsz;
      for (int i = 0; i < beats; i++) begin
        exp_addr.push_back(base + 32'(4 * i));
        if (cfg_err_en[t] && (base + 32'(4 * i) == cfg_err_addr[t])) begin
          hit = 1'b1;
        end
      end
      done_words += beats;
      if (cfg_incr[t]) begin
        base += 32'(4 * beats);
      end
    end
    return done_words;
  endfunction

  task automatic set_up_transfers();
    for (int t = 0; t < NUM_XFERS; t++) begin
      cfg_addr[t] = 32'h1000_0000 + (rand_bits(12) << 2);
      cfg_incr[t] = 1'b1;
      cfg_slow[t] = 1'b0;
      cfg_err_en[t] = 1'b0;
      cfg_err_addr[t] = '0;
    end
    cfg_len[0] = 32'd4 + rand_bits(7);
    cfg_burst[0] = 4'(rand_bits(4));
    // Fixed mode
    cfg_len[1] = 32'd16 + rand_bits(6);
    cfg_burst[1] = 4'(32'd2 + rand_bits(3));
    cfg_incr[1] = 1'b0;
    // Burst size 0 with 1 or 2 trailing bytes
    cfg_len[2] = 32'd4 * (32'd3 + rand_bits(3)) + 32'd1 + rand_bits(1);
    cfg_burst[2] = 4'd0;
    cfg_incr[2] = 1'b0;
    // Long bursts against a slowly draining FIFO
    cfg_len[3] = 32'd4 * (32'd40 + rand_bits(4));
    cfg_burst[3] = 4'(32'd12 + rand_bits(2));
    cfg_slow[3] = 1'b1;
    // Bad response somewhere in bursts 1 to 3 followed by a clean transfer
    cfg_len[4] = 32'd80;
    cfg_burst[4] = 4'd4;
    cfg_err_en[4] = 1'b1;
    cfg_err_addr[4] = cfg_addr[4] + 32'd4 * (32'd5 + rand_bits(3));
    cfg_len[5] = 32'd34;
    cfg_burst[5] = 4'd3;
  endtask

  // ------------------------------------------------------------------------
  // Memory and TX FIFO models
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    if (resetn) begin
      if (fifo_tx_we_o) begin
        if (tx_level_i == 5'(DEPTH)) begin
          report_failure("TX FIFO push while the FIFO level was full");
        end
        got_data.push_back(fifo_tx_data_o);
        fifo_level++;
      end
      if (fifo_level > DEPTH) begin
        report_failure("TX FIFO model level went above its depth");
      end
      if (fifo_level > 0) begin
        if (slow_drain ? (rand_bits(2) == 32'd3) : (rand_bits(1) == 32'd1)) begin
          fifo_level--;
        end
      end
      tx_level_i = 5'(fifo_level);
      if (dma_done_set_o) begin
        done_count++;
      end

      // R channel holds valid until taken
      rvalid_i = r_busy && (r_wait == 0);
      if (r_busy && r_wait > 0) begin
        r_wait--;
      end
      rdata_i = r_addr ^ PATTERN;
      rresp_i = (err_en && r_addr == err_addr) ? 2'b10 : 2'b00;
      arready_i = arvalid_o && !r_busy && (ar_wait == 0);
      if (arvalid_o && !r_busy && ar_wait > 0) begin
        ar_wait--;
      end

      // Handshakes that the next rising edge will see
      #1;
      if (rvalid_i && rready_o) begin
        r_busy = 1'b0;
      end
      if (arvalid_o && arready_i) begin
        got_addr.push_back(araddr_o);
        r_addr = araddr_o;
        r_busy = 1'b1;
        r_wait = int'(rand_bits(2));
        ar_wait = int'(rand_bits(2));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the DMA never finished", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Transfers and tests
  // ------------------------------------------------------------------------
  task automatic run_transfer(input int t);
    int n_exp;
    int done_before;
    int n;
    n_exp = expected_reads(t);
    got_addr.delete();
    got_data.delete();
    slow_drain = cfg_slow[t];
    err_en = cfg_err_en[t];
    err_addr = cfg_err_addr[t];
    done_before = done_count;
    @(negedge clk);
    dma_addr_i = cfg_addr[t];
    dma_len_i = cfg_len[t];
    burst_size_i = cfg_burst[t];
    incr_addr_i = cfg_incr[t];
    dma_en_i = 1'b1;
    @(negedge clk);
    dma_en_i = 1'b0;
    if (busy_o !== 1'b1) begin
      report_value("busy_o", 32'(busy_o), 32'h1);
    end
    if (axi_err_o !== 1'b0) begin
      report_value("axi_err_o", 32'(axi_err_o), 32'h0);
    end
    while (done_count == done_before) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    if (done_count != done_before + 1) begin
      report_value("dma_done_set_o pulses", 32'(done_count - done_before), 32'h1);
    end
    if (busy_o !== 1'b0) begin
      report_value("busy_o", 32'(busy_o), 32'h0);
    end
    if (axi_err_o !== cfg_err_en[t]) begin
      report_value("axi_err_o", 32'(axi_err_o), 32'(cfg_err_en[t]));
    end
    if (got_addr.size() != n_exp) begin
      report_value("araddr_o count", 32'(got_addr.size()), 32'(n_exp));
    end
    if (got_data.size() != n_exp) begin
      report_value("fifo_tx_we_o count", 32'(got_data.size()), 32'(n_exp));
    end
    if (cfg_err_en[t] && got_data.size() >= cfg_len[t] / 4) begin
      report_failure("transfer with a bad response was not cut short");
    end
    n = (got_data.size() < n_exp) ? got_data.size() : n_exp;
    for (int i = 0; i < n; i++) begin
      if (got_data[i] !== (exp_addr[i] ^ PATTERN)) begin
        report_value("fifo_tx_data_o", got_data[i], exp_addr[i] ^ PATTERN);
      end
    end
    n = (got_addr.size() < n_exp) ? got_addr.size() : n_exp;
    for (int i = 0; i < n; i++) begin
      if (got_addr[i] !== exp_addr[i]) begin
        report_value("araddr_o", got_addr[i], exp_addr[i]);
      end
    end
  endtask

  task automatic close_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL with %0d errors", num, name, errors - err_before);
    end
  endtask

  initial begin
    int err_before;
    int total_words;
    resetn = 1'b0;
    dma_en_i = 1'b0;
    burst_size_i = '0;
    incr_addr_i = 1'b0;
    dma_addr_i = '0;
    dma_len_i = '0;
    tx_level_i = '0;
    arready_i = 1'b0;
    rdata_i = '0;
    rvalid_i = 1'b0;
    rresp_i = '0;
    set_up_transfers();
    total_words = 0;
    for (int t = 0; t < NUM_XFERS; t++) begin
      total_words += expected_reads(t);
    end
    cycle_limit = 20 * total_words + 200 * NUM_TESTS;
    repeat (2) @(negedge clk);
    resetn = 1'b1;

    err_before = errors;
    run_transfer(0);
    close_test(1, "increment mode", err_before);
    err_before = errors;
    run_transfer(1);
    close_test(2, "fixed mode", err_before);
    err_before = errors;
    run_transfer(2);
    close_test(3, "burst size 0 with trailing bytes", err_before);
    err_before = errors;
    run_transfer(3);
    close_test(4, "FIFO back-pressure", err_before);
    err_before = errors;
    run_transfer(4);
    run_transfer(5);
    close_test(5, "error response and restart", err_before);

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
source/dma_pkg.sv
source/dma_sequencer.sv
source/dma_burst_counter.sv
source/axi_read_beats.sv
source/dma_read_top.sv
sim/tb_clock_gen.sv
sim/dma_read_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA read testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module dma_read_tb -o dma_read_sim

./obj_dir/dma_read_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
